/* common/soc_mem_pkg.sv */
package soc_mem_pkg;

    // data word and byte lanes
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = DATA_WIDTH / 8;

    // two banks of 256 words
    localparam int N_BANKS         = 2;
    localparam int BANK_WORDS      = 256;
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_WORDS);

    // global word address, top bit picks the bank
    localparam int WORD_ADDR_WIDTH = BANK_ADDR_WIDTH + $clog2(N_BANKS);

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [BE_WIDTH-1:0]        be_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // master side request, travels next to a req bit
    typedef struct packed {
        word_addr_t addr;
        logic       we;    // 1 = write, 0 = read
        be_t        be;
        data_t      wdata;
    } mem_req_t;

    // what a bank rw port sees once the bank bit is stripped
    typedef struct packed {
        bank_addr_t addr;
        logic       we;
        be_t        be;
        data_t      wdata;
    } bank_req_t;

endpackage

/* hw/sram_bank.sv */
`timescale 1ns/1ps

// behavioral model of a 1rw + 1r macro
module sram_bank
    import soc_mem_pkg::*;
(
    input  logic       clk_i,

    // port 0, read/write
    input  logic       cs_i,
    input  bank_req_t  req_i,
    output data_t      rdata_o,

    // port 1, read only
    input  logic       rcs_i,
    input  bank_addr_t raddr_i,
    output data_t      rrdata_o
);

    data_t mem [BANK_WORDS];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (req_i.we) begin
                for (int i = 0; i < BE_WIDTH; i++) begin
                    if (req_i.be[i]) begin
                        mem[req_i.addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
                    end
                end
            end
            rdata_o <= mem[req_i.addr]; // old word on a write
        end
    end

    // same edge as a port 0 write, so it still sees the old word
    always_ff @(posedge clk_i) begin
        if (rcs_i) begin
            rrdata_o <= mem[raddr_i];
        end
    end

endmodule

/* hw/wb_host_bridge.sv */
`timescale 1ns/1ps

module wb_host_bridge
    import soc_mem_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset,

    // wishbone classic slave side
    input  logic     wbs_cyc_i,
    input  logic     wbs_stb_i,
    input  logic     wbs_we_i,
    input  be_t      wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  data_t    wbs_dat_i,
    output logic     wbs_ack_o,
    output data_t    wbs_dat_o,

    // data bus master side
    output logic     req_o,
    output mem_req_t req_data_o,
    input  logic     gnt_i,
    input  logic     rvalid_i,
    input  data_t    rdata_i
);

    logic pending_q; // granted, waiting for rvalid

    always_ff @(posedge clk_i) begin
        if (reset) begin
            pending_q <= 1'b0;
        end else if (gnt_i) begin
            pending_q <= 1'b1;
        end else if (rvalid_i) begin
            pending_q <= 1'b0;
        end
    end

    // one request per wishbone cycle
    assign req_o = wbs_cyc_i & wbs_stb_i & ~pending_q;

    // byte address to word address, upper bits alias
    assign req_data_o.addr  = wbs_adr_i[WORD_ADDR_WIDTH+1:2];
    assign req_data_o.we    = wbs_we_i;
    assign req_data_o.be    = wbs_sel_i;
    assign req_data_o.wdata = wbs_dat_i;

    // ack is the bus response itself
    assign wbs_ack_o = rvalid_i;
    assign wbs_dat_o = rdata_i;

endmodule

/* interconnect/data_xbar.sv */
`timescale 1ns/1ps

module data_xbar
    import soc_mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       reset,

    // masters: 0 = wishbone bridge, 1 = core data port
    input  logic      [1:0]            m_req_i,
    input  mem_req_t  [1:0]            m_req_data_i,
    output logic      [1:0]            m_gnt_o,
    output logic      [1:0]            m_rvalid_o,
    output data_t     [1:0]            m_rdata_o,

    // bank rw ports
    output logic      [N_BANKS-1:0]    bank_cs_o,
    output bank_req_t [N_BANKS-1:0]    bank_req_o,
    input  data_t     [N_BANKS-1:0]    bank_rdata_i
);

    localparam int N_MASTERS = 2;

    logic [N_MASTERS-1:0] m_bank;                 // target bank per master
    logic [N_MASTERS-1:0] want [N_BANKS];         // per bank request vector
    logic [N_BANKS-1:0]   winner;                 // granted master per bank
    logic [N_BANKS-1:0]   last_gnt_q;             // last granted master per bank
    logic [N_MASTERS-1:0] rvalid_q;
    logic [N_MASTERS-1:0] bank_sel_q;             // bank that served each master

    always_comb begin
        for (int m = 0; m < N_MASTERS; m++) begin
            m_bank[m] = m_req_data_i[m].addr[WORD_ADDR_WIDTH-1];
        end

        for (int b = 0; b < N_BANKS; b++) begin
            for (int m = 0; m < N_MASTERS; m++) begin
                want[b][m] = m_req_i[m] && (int'(m_bank[m]) == b);
            end

            // round robin on conflict, otherwise whoever asks
            if (&want[b]) begin
                winner[b] = ~last_gnt_q[b];
            end else begin
                winner[b] = want[b][1];
            end

            bank_cs_o[b]        = |want[b];
            bank_req_o[b].addr  = m_req_data_i[winner[b]].addr[BANK_ADDR_WIDTH-1:0];
            bank_req_o[b].we    = m_req_data_i[winner[b]].we;
            bank_req_o[b].be    = m_req_data_i[winner[b]].be;
            bank_req_o[b].wdata = m_req_data_i[winner[b]].wdata;
        end

        for (int m = 0; m < N_MASTERS; m++) begin
            m_gnt_o[m] = m_req_i[m] && (winner[m_bank[m]] == 1'(m));
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            last_gnt_q <= '1; // master 0 goes first
            rvalid_q   <= '0;
        end else begin
            for (int b = 0; b < N_BANKS; b++) begin
                if (bank_cs_o[b]) begin
                    last_gnt_q[b] <= winner[b];
                end
            end
            rvalid_q <= m_gnt_o; // reads and writes both answer
        end
    end

    always_ff @(posedge clk_i) begin
        for (int m = 0; m < N_MASTERS; m++) begin
            if (m_gnt_o[m]) begin
                bank_sel_q[m] <= m_bank[m];
            end
        end
    end

    assign m_rvalid_o = rvalid_q;

    always_comb begin
        for (int m = 0; m < N_MASTERS; m++) begin
            m_rdata_o[m] = bank_rdata_i[bank_sel_q[m]];
        end
    end

endmodule

/* interconnect/instr_read_port.sv */
`timescale 1ns/1ps

module instr_read_port
    import soc_mem_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset,

    // fetch side
    input  logic                   instr_req_i,
    input  word_addr_t             instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output data_t                  instr_rdata_o,

    // bank read-only ports
    output logic   [N_BANKS-1:0]   bank_rcs_o,
    output bank_addr_t             bank_raddr_o,
    input  data_t  [N_BANKS-1:0]   bank_rdata_i
);

    logic rvalid_q;
    logic bank_q; // bank of the outstanding fetch

    assign instr_gnt_o  = instr_req_i; // never stalls
    assign bank_raddr_o = instr_addr_i[BANK_ADDR_WIDTH-1:0];

    always_comb begin
        for (int b = 0; b < N_BANKS; b++) begin
            bank_rcs_o[b] = instr_req_i && (int'(instr_addr_i[WORD_ADDR_WIDTH-1]) == b);
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= instr_req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            bank_q <= instr_addr_i[WORD_ADDR_WIDTH-1];
        end
    end

    assign instr_rvalid_o = rvalid_q;
    assign instr_rdata_o  = bank_rdata_i[bank_q];

endmodule

/* hw/soc_mem_top.sv */
`timescale 1ns/1ps

module soc_mem_top
    import soc_mem_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset,

    // wishbone host
    input  logic        wbs_cyc_i,
    input  logic        wbs_stb_i,
    input  logic        wbs_we_i,
    input  be_t         wbs_sel_i,
    input  logic [31:0] wbs_adr_i,
    input  data_t       wbs_dat_i,
    output logic        wbs_ack_o,
    output data_t       wbs_dat_o,

    // core data port
    input  logic        core_req_i,
    input  mem_req_t    core_req_data_i,
    output logic        core_gnt_o,
    output logic        core_rvalid_o,
    output data_t       core_rdata_o,

    // instruction fetch
    input  logic        instr_req_i,
    input  word_addr_t  instr_addr_i,
    output logic        instr_gnt_o,
    output logic        instr_rvalid_o,
    output data_t       instr_rdata_o
);

    logic      [1:0]         m_req;
    mem_req_t  [1:0]         m_req_data;
    logic      [1:0]         m_gnt;
    logic      [1:0]         m_rvalid;
    data_t     [1:0]         m_rdata;

    logic      [N_BANKS-1:0] bank_cs;
    bank_req_t [N_BANKS-1:0] bank_req;
    data_t     [N_BANKS-1:0] bank_rdata;
    logic      [N_BANKS-1:0] bank_rcs;
    bank_addr_t              bank_raddr;
    data_t     [N_BANKS-1:0] bank_rrdata;

    wb_host_bridge i_wb_host_bridge (
        .clk_i      (clk_i),
        .reset      (reset),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_we_i   (wbs_we_i),
        .wbs_sel_i  (wbs_sel_i),
        .wbs_adr_i  (wbs_adr_i),
        .wbs_dat_i  (wbs_dat_i),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o),
        .req_o      (m_req[0]),
        .req_data_o (m_req_data[0]),
        .gnt_i      (m_gnt[0]),
        .rvalid_i   (m_rvalid[0]),
        .rdata_i    (m_rdata[0])
    );

    // core port is master 1
    assign m_req[1]      = core_req_i;
    assign m_req_data[1] = core_req_data_i;
    assign core_gnt_o    = m_gnt[1];
    assign core_rvalid_o = m_rvalid[1];
    assign core_rdata_o  = m_rdata[1];

    data_xbar i_data_xbar (
        .clk_i        (clk_i),
        .reset        (reset),
        .m_req_i      (m_req),
        .m_req_data_i (m_req_data),
        .m_gnt_o      (m_gnt),
        .m_rvalid_o   (m_rvalid),
        .m_rdata_o    (m_rdata),
        .bank_cs_o    (bank_cs),
        .bank_req_o   (bank_req),
        .bank_rdata_i (bank_rdata)
    );

    instr_read_port i_instr_read_port (
        .clk_i          (clk_i),
        .reset          (reset),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .bank_rcs_o     (bank_rcs),
        .bank_raddr_o   (bank_raddr),
        .bank_rdata_i   (bank_rrdata)
    );

    sram_bank i_sram_bank_0 (
        .clk_i    (clk_i),
        .cs_i     (bank_cs[0]),
        .req_i    (bank_req[0]),
        .rdata_o  (bank_rdata[0]),
        .rcs_i    (bank_rcs[0]),
        .raddr_i  (bank_raddr),
        .rrdata_o (bank_rrdata[0])
    );

    sram_bank i_sram_bank_1 (
        .clk_i    (clk_i),
        .cs_i     (bank_cs[1]),
        .req_i    (bank_req[1]),
        .rdata_o  (bank_rdata[1]),
        .rcs_i    (bank_rcs[1]),
        .raddr_i  (bank_raddr),
        .rrdata_o (bank_rrdata[1])
    );

endmodule

/* sim/tb_soc_mem_top.sv */
`timescale 1ns/1ps

module tb_soc_mem_top
    import soc_mem_pkg::*;
();

    localparam int N_FILL  = 2 * BANK_WORDS;
    localparam int N_WB    = 64;
    localparam int N_CORE  = 64;
    localparam int N_CONC  = 48;   // pairs, each also read back
    localparam int N_FETCH = 64;
    localparam int N_ALIAS = 24;
    localparam int N_TXN   = N_FILL + N_WB + N_CORE + 4 * N_CONC + N_FETCH + 2 * N_ALIAS;
    localparam int TIMEOUT = 20 * N_TXN;

    logic        clk_i, reset;
    logic        wbs_cyc_i, wbs_stb_i, wbs_we_i, wbs_ack_o;
    be_t         wbs_sel_i;
    logic [31:0] wbs_adr_i;
    data_t       wbs_dat_i, wbs_dat_o;
    logic        core_req_i, core_gnt_o, core_rvalid_o;
    mem_req_t    core_req_data_i;
    data_t       core_rdata_o;
    logic        instr_req_i, instr_gnt_o, instr_rvalid_o;
    word_addr_t  instr_addr_i;
    data_t       instr_rdata_o;

    data_t       model [2*BANK_WORDS];   // reference contents of both banks
    logic [31:0] lfsr = 32'h6c93468a;
    int unsigned cycle_count = 0;
    word_addr_t  touched [$];

    soc_mem_top i_soc_mem_top (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    function automatic data_t fill_word(word_addr_t a);
        return {7'h55, a, 7'h2a, ~a};
    endfunction

    function automatic mem_req_t rand_req(word_addr_t a);
        mem_req_t r;
        r.addr  = a;
        r.we    = 1'(rand_bits(1));
        r.be    = be_t'(rand_bits(BE_WIDTH));
        r.wdata = rand_bits(DATA_WIDTH);
        return r;
    endfunction

    function automatic void model_write(word_addr_t a, be_t be, data_t d);
        for (int i = 0; i < BE_WIDTH; i++) begin
            if (be[i]) model[a][8*i +: 8] = d[8*i +: 8];   // masked lanes keep old byte
        end
    endfunction

    task automatic check_data(data_t got, data_t exp, string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Verification failed");
            $fatal(1, "handshake mismatch");
        end
    endtask

    task automatic wb_access(logic [31:0] adr, logic we, be_t sel, data_t dat,
                             output data_t rdata);
        @(negedge clk_i);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = sel;
        wbs_adr_i = adr;
        wbs_dat_i = dat;
        @(posedge clk_i);
        while (wbs_ack_o !== 1'b1) begin
            @(posedge clk_i);
        end
        rdata = wbs_dat_o;
        @(negedge clk_i);
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        @(posedge clk_i);
        check_flag(wbs_ack_o, 1'b0, "wishbone ack after completion");   // only one ack
    endtask

    task automatic core_access(mem_req_t r, output data_t rdata);
        @(negedge clk_i);
        core_req_i      = 1'b1;
        core_req_data_i = r;
        @(posedge clk_i);
        while (core_gnt_o !== 1'b1) begin
            @(posedge clk_i);
        end
        check_flag(core_rvalid_o, 1'b0, "core rvalid in gnt cycle");
        @(negedge clk_i);
        core_req_i = 1'b0;
        @(posedge clk_i);
        check_flag(core_rvalid_o, 1'b1, "core rvalid one cycle after gnt");
        rdata = core_rdata_o;
    endtask

    task automatic fetch_check(word_addr_t a);
        @(negedge clk_i);
        instr_req_i  = 1'b1;
        instr_addr_i = a;
        @(posedge clk_i);
        check_flag(instr_gnt_o, 1'b1, "instr gnt with req");
        check_flag(instr_rvalid_o, 1'b0, "instr rvalid in req cycle");
        @(negedge clk_i);
        instr_req_i = 1'b0;
        @(posedge clk_i);
        check_flag(instr_gnt_o, 1'b0, "instr gnt without req");
        check_flag(instr_rvalid_o, 1'b1, "instr rvalid one cycle after req");
        check_data(instr_rdata_o, model[a], "instr fetch");
    endtask

    initial begin
        data_t      rd, rd2;
        mem_req_t   wr, cr;
        word_addr_t a;
        clk_i           = 1'b0;
        reset           = 1'b1;
        wbs_cyc_i       = 1'b0;
        wbs_stb_i       = 1'b0;
        wbs_we_i        = 1'b0;
        wbs_sel_i       = '0;
        wbs_adr_i       = '0;
        wbs_dat_i       = '0;
        core_req_i      = 1'b0;
        core_req_data_i = '0;
        instr_req_i     = 1'b0;
        instr_addr_i    = '0;

        // 16 cycles of reset, responses stay quiet
        for (int i = 0; i <= 16; i++) begin
            @(negedge clk_i);
            if (i == 15) reset = 1'b0;
            check_flag(wbs_ack_o, 1'b0, "wbs_ack_o in reset");
            check_flag(core_rvalid_o, 1'b0, "core_rvalid_o in reset");
            check_flag(instr_rvalid_o, 1'b0, "instr_rvalid_o in reset");
        end

        // known contents in every word first
        for (int i = 0; i < N_FILL; i++) begin
            cr = '{addr: word_addr_t'(i), we: 1'b1, be: '1, wdata: fill_word(word_addr_t'(i))};
            core_access(cr, rd);
            model[i] = cr.wdata;
        end

        for (int i = 0; i < N_WB; i++) begin
            wr = rand_req(word_addr_t'(rand_bits(WORD_ADDR_WIDTH)));
            wb_access({21'b0, wr.addr, 2'b00}, wr.we, wr.be, wr.wdata, rd);
            if (wr.we) model_write(wr.addr, wr.be, wr.wdata);
            else check_data(rd, model[wr.addr], "wishbone read");
        end

        for (int i = 0; i < N_CORE; i++) begin
            cr = rand_req(word_addr_t'(rand_bits(WORD_ADDR_WIDTH)));
            core_access(cr, rd);
            if (cr.we) model_write(cr.addr, cr.be, cr.wdata);
            else check_data(rd, model[cr.addr], "core read");
        end

        // both masters at once, bank picked by coin flip
        for (int i = 0; i < N_CONC; i++) begin
            wr = rand_req(word_addr_t'(rand_bits(WORD_ADDR_WIDTH)));
            a  = word_addr_t'(rand_bits(WORD_ADDR_WIDTH));
            a[WORD_ADDR_WIDTH-1] = wr.addr[WORD_ADDR_WIDTH-1] ^ 1'(rand_bits(1));
            if (a == wr.addr) a[0] = ~a[0];   // same bank, distinct word
            cr = rand_req(a);
            fork
                wb_access({21'b0, wr.addr, 2'b00}, wr.we, wr.be, wr.wdata, rd);
                core_access(cr, rd2);
            join
            if (!wr.we) check_data(rd, model[wr.addr], "concurrent wishbone read");
            if (!cr.we) check_data(rd2, model[cr.addr], "concurrent core read");
            if (wr.we) model_write(wr.addr, wr.be, wr.wdata);
            if (cr.we) model_write(cr.addr, cr.be, cr.wdata);
            touched.push_back(wr.addr);
            touched.push_back(cr.addr);
        end
        foreach (touched[i]) begin
            wb_access({21'b0, touched[i], 2'b00}, 1'b0, '1, '0, rd);
            check_data(rd, model[touched[i]], "readback after concurrent phase");
        end

        for (int i = 0; i < N_FETCH; i++) begin
            fetch_check(word_addr_t'(rand_bits(WORD_ADDR_WIDTH)));
        end

        // write through a high alias, read through the plain address
        for (int i = 0; i < N_ALIAS; i++) begin
            wr = rand_req(word_addr_t'(rand_bits(WORD_ADDR_WIDTH)));
            wb_access({21'(rand_bits(21)) | 21'h1, wr.addr, 2'b00}, 1'b1, wr.be, wr.wdata, rd);
            model_write(wr.addr, wr.be, wr.wdata);
            wb_access({21'b0, wr.addr, 2'b00}, 1'b0, '1, '0, rd);
            check_data(rd, model[wr.addr], "aliased wishbone write");
        end

        $display("Verification passed");
        $finish;
    end

endmodule

/* soc_mem_top.f */
common/soc_mem_pkg.sv
hw/sram_bank.sv
hw/wb_host_bridge.sv
interconnect/data_xbar.sv
interconnect/instr_read_port.sv
hw/soc_mem_top.sv
sim/tb_soc_mem_top.sv

/* Bender.yml */
package:
  name: soc_mem

sources:
  - common/soc_mem_pkg.sv
  - hw/sram_bank.sv
  - hw/wb_host_bridge.sv
  - interconnect/data_xbar.sv
  - interconnect/instr_read_port.sv
  - hw/soc_mem_top.sv
  - target: simulation
    files:
      - sim/tb_soc_mem_top.sv
